// File: filelist.f
fpu_pkg.sv
fp_half_lane.sv
fpu_both.sv
fpu_csr_apb.sv
fpu_top.sv
fpu_sva.sv
tb_fpu_top.sv

// File: Makefile
TOP = tb_fpu_top

all: run

obj_dir/V$(TOP): filelist.f *.sv
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

lint:
	verilator --lint-only -Wall --timing --assert -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// File: tb_fpu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the fpu compare top
// random compare, min and max against
// a queue model, plus apb csr checks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_fpu_top;
  import fpu_pkg::*;

  localparam int N_CMP   = 1000;
  localparam int N_MM    = 300;
  localparam int N_MIX   = 400;
  localparam int N_REQ   = N_CMP + 2 * N_MM + N_MIX + 1;
  localparam int APB_CYC = 80;
  localparam int LIMIT   = 4 * N_REQ + APB_CYC + 200;

  typedef struct packed {
    fp_vec_t     data;
    fp_flags_t   flags;
    logic [31:0] cyc;
  } exp_t;

  logic        clk = 1'b0;
  logic        arst_n;
  fpu_req_t    req;
  fpu_rsp_t    rsp;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic [31:0] rng = 32'd61;
  logic [31:0] cyc = '0;
  logic        mode;
  int          err_val = 0;
  int          err_seq = 0;
  exp_t        exp_q[$];

  fpu_top u_dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .req     (req),
    .rsp     (rsp),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= LIMIT) begin
      $display("timeout after %0d cycles, responses still pending", LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng = x;
    return x;
  endfunction

  function automatic fp_word_t make_nan(logic [31:0] w);
    return {w[31], 8'hff, w[22:1], 1'b1};
  endfunction

  // special values mixed in with plain random words.
  function automatic fp_word_t rand_word();
    logic [31:0] r;
    logic [31:0] w;
    r = xorshift32();
    w = xorshift32();
    case (r[3:0])
      4'd0: return 32'h0000_0000;
      4'd1: return 32'h8000_0000;
      4'd2: return {w[31], 8'hff, 23'd0};
      4'd3: return make_nan(w);
      4'd4: return {w[31], 8'h80, w[22:0]};
      default: return w;
    endcase
  endfunction

  function automatic fp_vec_t rand_vec();
    return {rand_word(), rand_word()};
  endfunction

  function automatic logic nan_word(fp_word_t w);
    return (w[30:23] == 8'hff) && (w[22:0] != 23'd0);
  endfunction

  // unsigned key that sorts like the float value.
  function automatic logic [31:0] sort_key(fp_word_t w);
    return w[31] ? ~w : (w | 32'h8000_0000);
  endfunction

  function automatic fp_flags_t order_of(fp_word_t a, fp_word_t b);
    fp_flags_t f;
    f = '0;
    if (nan_word(a) || nan_word(b))
      f[FLAG_UN] = 1'b1;
    else if (a[30:0] == 31'd0 && b[30:0] == 31'd0)
      f[FLAG_EQ] = 1'b1;
    else if (sort_key(a) < sort_key(b))
      f[FLAG_LT] = 1'b1;
    else if (sort_key(a) > sort_key(b))
      f[FLAG_GT] = 1'b1;
    else
      f[FLAG_EQ] = 1'b1;
    return f;
  endfunction

  function automatic fp_word_t half_result(fpu_op_t op, fp_word_t a, fp_word_t b,
                                           logic nan_m, fp_flags_t f);
    if (op == OP_CMP_LO || op == OP_CMP_HI)
      return f[FLAG_LT] ? 32'hffff_ffff : 32'h0;
    if (nan_word(a) || nan_word(b)) begin
      if (nan_m && !nan_word(a))
        return a;
      if (nan_m && !nan_word(b))
        return b;
      return QNAN;
    end
    if (op == OP_MIN)
      return f[FLAG_GT] ? b : a;
    return f[FLAG_LT] ? b : a;
  endfunction

  task automatic check_vec(string name, fp_vec_t got, fp_vec_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      err_val++;
    end
  endtask

  task automatic check_flags(string name, fp_flags_t got, fp_flags_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      err_val++;
    end
  endtask

  task automatic check_apb(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      err_val++;
    end
  endtask

  task automatic send_req(fpu_op_t op, fp_vec_t a, fp_vec_t b);
    exp_t      e;
    fp_flags_t fh;
    fp_flags_t fl;
    fh = order_of(a[63:32], b[63:32]);
    fl = order_of(a[31:0], b[31:0]);
    @(posedge clk);
    #2;
    req.valid = 1'b1;
    req.op    = op;
    req.a     = a;
    req.b     = b;
    e.data  = {half_result(op, a[63:32], b[63:32], mode, fh),
               half_result(op, a[31:0], b[31:0], mode, fl)};
    e.flags = (op == OP_CMP_HI) ? fh : fl;
    // cycle in which the request is presented.
    e.cyc   = cyc;
    exp_q.push_back(e);
  endtask

  task automatic go_idle(int n);
    repeat (n) begin
      @(posedge clk);
      #2;
      req.valid = 1'b0;
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0)
      @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  task automatic apb_xfer(logic wr, apb_addr_t addr, logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk);
    #2;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #2;
    apb_req.penable = 1'b1;
    @(negedge clk);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    // no wait states on this bus.
    check_apb("apb_rsp.pready", {31'd0, apb_rsp.pready}, 32'd1);
    @(posedge clk);
    #2;
    apb_req = '0;
  endtask

  task automatic apb_write(apb_addr_t addr, logic [31:0] wdata);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, wdata, rd, err);
  endtask

  task automatic apb_expect(apb_addr_t addr, logic [31:0] exp_data, logic exp_err);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b0, addr, 32'd0, rd, err);
    check_apb("apb_rsp.prdata", rd, exp_data);
    check_apb("apb_rsp.pslverr", {31'd0, err}, {31'd0, exp_err});
  endtask

  // responses checked at the falling edge.
  always @(negedge clk) begin
    exp_t e;
    if (rsp.valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("unexpected response at cycle %0d", cyc);
        err_seq++;
      end else begin
        e = exp_q.pop_front();
        if (cyc != e.cyc + 4) begin
          $display("response at cycle %0d has wrong latency, request was at cycle %0d",
                   cyc, e.cyc);
          err_seq++;
        end
        check_vec("rsp.data", rsp.data, e.data);
        check_flags("rsp.flags", rsp.flags, e.flags);
      end
    end else if (exp_q.size() != 0 && cyc >= exp_q[0].cyc + 4) begin
      $display("missing response for the request of cycle %0d", exp_q[0].cyc);
      void'(exp_q.pop_front());
      err_seq++;
    end
  end

  initial begin
    fp_vec_t     a;
    fp_vec_t     b;
    logic [31:0] r;
    arst_n  = 1'b0;
    req     = '0;
    apb_req = '0;
    mode    = 1'b0;
    repeat (16) @(posedge clk);
    if (rsp.valid !== 1'b0) begin
      $display("rsp.valid is not low during reset");
      err_seq++;
    end
    #2;
    arst_n = 1'b1;
    apb_expect(CSR_CTRL, 32'd0, 1'b0);
    apb_expect(CSR_STATUS, 32'd0, 1'b0);

    // back to back compares of both kinds.
    for (int i = 0; i < N_CMP; i++) begin
      r = xorshift32();
      send_req(r[0] ? OP_CMP_HI : OP_CMP_LO, rand_vec(), rand_vec());
    end
    go_idle(1);
    drain();

    // min and max, nan mode 0, with some ties.
    for (int i = 0; i < N_MM; i++) begin
      r = xorshift32();
      a = rand_vec();
      b = rand_vec();
      // opposite signed zeros tie, so a must come back.
      if (r[2:1] == 2'd0) begin
        a[31:0] = {r[8], 31'd0};
        b[31:0] = {~r[8], 31'd0};
      end
      if (r[2:1] == 2'd1) begin
        a[63:32] = {r[9], 31'd0};
        b[63:32] = {~r[9], 31'd0};
      end
      send_req(r[0] ? OP_MAX : OP_MIN, a, b);
    end
    go_idle(1);
    drain();

    // nan mode 1.
    apb_write(CSR_CTRL, 32'd1);
    mode = 1'b1;
    apb_expect(CSR_CTRL, 32'd1, 1'b0);
    for (int i = 0; i < N_MM; i++) begin
      r = xorshift32();
      a = rand_vec();
      b = rand_vec();
      if (r[1] && r[3])
        a[63:32] = make_nan(r);
      if (r[1] && !r[3])
        b[63:32] = make_nan(r);
      if (r[2] && r[4])
        a[31:0] = make_nan(xorshift32());
      if (r[2] && !r[4])
        b[31:0] = make_nan(xorshift32());
      if (r[7:5] == 3'd0) begin
        a[31:0] = QNAN;
        b[31:0] = make_nan(r);
      end
      send_req(r[0] ? OP_MAX : OP_MIN, a, b);
    end
    go_idle(1);
    drain();

    // mixed ops with random gaps.
    apb_write(CSR_CTRL, 32'd0);
    mode = 1'b0;
    for (int i = 0; i < N_MIX; i++) begin
      r = xorshift32();
      send_req(r[1:0], rand_vec(), rand_vec());
      go_idle(int'(r[3:2]));
    end
    go_idle(1);
    drain();

    // sticky invalid and unmapped address.
    apb_write(CSR_STATUS, 32'd1);
    apb_expect(CSR_STATUS, 32'd0, 1'b0);
    a = rand_vec();
    b = rand_vec();
    a[31:0] = QNAN;
    send_req(OP_CMP_LO, a, b);
    go_idle(1);
    drain();
    apb_expect(CSR_STATUS, 32'd1, 1'b0);
    apb_write(CSR_STATUS, 32'd1);
    apb_expect(CSR_STATUS, 32'd0, 1'b0);
    apb_expect(8'h08, 32'd0, 1'b1);

    repeat (8) @(posedge clk);
    if (exp_q.size() != 0) begin
      $display("%0d requests never got a response", exp_q.size());
      err_seq++;
    end
    $display("errors: %0d value, %0d sequence", err_val, err_seq);
    if (err_val == 0 && err_seq == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// File: fpu_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// assertions for the two half unit
// response timing and flag encoding.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module fpu_sva (
  input logic              clk,
  input logic              arst_n,
  input fpu_pkg::fpu_req_t req,
  input fpu_pkg::fpu_rsp_t rsp
);
  import fpu_pkg::*;

  // responses trail requests by the pipeline depth.
  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
    rsp.valid == $past(req.valid, FPU_LATENCY))
    else $error("rsp.valid does not follow req.valid by %0d cycles", FPU_LATENCY);

  a_flags_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    rsp.valid |-> $onehot0(rsp.flags))
    else $error("more than one flag bit high in rsp.flags %h", rsp.flags);

  a_reset_quiet: assert property (@(posedge clk)
    !arst_n |-> !rsp.valid)
    else $error("rsp.valid high during reset");

endmodule

bind fpu_both fpu_sva u_sva (
  .clk    (clk),
  .arst_n (arst_n),
  .req    (req),
  .rsp    (rsp)
);

// File: fpu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fpu compare top level
// csr block plus two half unit.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module fpu_top (
  input  logic              clk,
  input  logic              arst_n,
  input  fpu_pkg::fpu_req_t req,
  output fpu_pkg::fpu_rsp_t rsp,
  input  fpu_pkg::apb_req_t apb_req,
  output fpu_pkg::apb_rsp_t apb_rsp
);
  import fpu_pkg::*;

  logic     nan_mode;
  fpu_rsp_t both_rsp;

  fpu_csr_apb u_csr (
    .clk      (clk),
    .arst_n   (arst_n),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .rsp      (both_rsp),
    .nan_mode (nan_mode)
  );

  fpu_both u_both (
    .clk      (clk),
    .arst_n   (arst_n),
    .req      (req),
    .nan_mode (nan_mode),
    .rsp      (both_rsp)
  );

  assign rsp = both_rsp;

endmodule

// File: fpu_csr_apb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// apb register block
// nan mode control, sticky invalid.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module fpu_csr_apb (
  input  logic              clk,
  input  logic              arst_n,
  input  fpu_pkg::apb_req_t apb_req,
  output fpu_pkg::apb_rsp_t apb_rsp,
  input  fpu_pkg::fpu_rsp_t rsp,
  output logic              nan_mode
);
  import fpu_pkg::*;

  logic wr_en;
  logic hit_ctrl;
  logic hit_status;
  logic invalid_q;

  // writes land on the access edge.
  assign wr_en      = apb_req.psel && apb_req.penable && apb_req.pwrite;
  assign hit_ctrl   = (apb_req.paddr == CSR_CTRL);
  assign hit_status = (apb_req.paddr == CSR_STATUS);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      nan_mode <= 1'b0;
    end else if (wr_en && hit_ctrl) begin
      nan_mode <= apb_req.pwdata[0];
    end
  end

  // set beats write one to clear.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      invalid_q <= 1'b0;
    end else if (rsp.valid && rsp.flags[FLAG_UN]) begin
      invalid_q <= 1'b1;
    end else if (wr_en && hit_status && apb_req.pwdata[0]) begin
      invalid_q <= 1'b0;
    end
  end

  always_comb begin
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = 1'b0;
    apb_rsp.prdata  = '0;
    if (hit_ctrl) begin
      apb_rsp.prdata = {{(APB_DW-1){1'b0}}, nan_mode};
    end else if (hit_status) begin
      apb_rsp.prdata = {{(APB_DW-1){1'b0}}, invalid_q};
    end else begin
      apb_rsp.pslverr = apb_req.psel && apb_req.penable;
    end
  end

endmodule

// File: fpu_both.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two half simd compare unit
// high and low lanes share one op,
// flags picked by delayed opcode.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module fpu_both (
  input  logic             clk,
  input  logic             arst_n,
  input  fpu_pkg::fpu_req_t req,
  input  logic             nan_mode,
  output fpu_pkg::fpu_rsp_t rsp
);
  import fpu_pkg::*;

  logic      hi_valid;
  logic      lo_valid;
  fp_word_t  hi_data;
  fp_word_t  lo_data;
  fp_flags_t hi_flags;
  fp_flags_t lo_flags;

  // opcode follows the lanes.
  fpu_op_t   op_dly [FPU_LATENCY];

  fp_half_lane u_hi (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (req.valid),
    .op        (req.op),
    .a         (req.a[VEC_W-1:FP_W]),
    .b         (req.b[VEC_W-1:FP_W]),
    .nan_mode  (nan_mode),
    .out_valid (hi_valid),
    .out_data  (hi_data),
    .out_flags (hi_flags)
  );

  fp_half_lane u_lo (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (req.valid),
    .op        (req.op),
    .a         (req.a[FP_W-1:0]),
    .b         (req.b[FP_W-1:0]),
    .nan_mode  (nan_mode),
    .out_valid (lo_valid),
    .out_data  (lo_data),
    .out_flags (lo_flags)
  );

  always_ff @(posedge clk) begin
    op_dly[0] <= req.op;
    for (int i = 1; i < FPU_LATENCY; i++) begin
      op_dly[i] <= op_dly[i-1];
    end
  end

  always_comb begin
    rsp.valid = hi_valid | lo_valid;
    rsp.data  = {hi_data, lo_data};
    // only the high compare takes its flags from the high lane.
    if (op_dly[FPU_LATENCY-1] == OP_CMP_HI) begin
      rsp.flags = hi_flags;
    end else begin
      rsp.flags = lo_flags;
    end
  end

endmodule

// File: fp_half_lane.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single precision half lane
// four stage compare, min and max.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module fp_half_lane (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               in_valid,
  input  fpu_pkg::fpu_op_t   op,
  input  fpu_pkg::fp_word_t  a,
  input  fpu_pkg::fp_word_t  b,
  input  logic               nan_mode,
  output logic               out_valid,
  output fpu_pkg::fp_word_t  out_data,
  output fpu_pkg::fp_flags_t out_flags
);
  import fpu_pkg::*;

  function automatic logic is_nan(fp_word_t w);
    return (w[30:23] == 8'hff) && (w[22:0] != 23'd0);
  endfunction

  logic      s1_valid;
  logic      s2_valid;
  logic      s3_valid;
  fpu_op_t   s1_op;
  fpu_op_t   s2_op;
  fp_word_t  s1_a;
  fp_word_t  s1_b;
  fp_word_t  s2_a;
  fp_word_t  s2_b;
  logic      s1_mode;
  logic      s2_mode;
  logic      s1_a_nan;
  logic      s1_b_nan;
  logic      s2_a_nan;
  logic      s2_b_nan;
  logic      s1_a_neg;
  logic      s1_b_neg;
  logic      s1_a_zero;
  logic      s1_b_zero;
  logic      mag_lt;
  logic      mag_eq;
  fp_flags_t order_flags;
  fp_flags_t s2_flags;
  fp_flags_t s3_flags;
  fp_word_t  sel_data;
  fp_word_t  s3_data;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      s3_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      s2_valid  <= s1_valid;
      s3_valid  <= s2_valid;
      out_valid <= s3_valid;
    end
  end

  // magnitudes compare as unsigned integers.
  assign mag_lt = s1_a[30:0] < s1_b[30:0];
  assign mag_eq = s1_a[30:0] == s1_b[30:0];

  always_comb begin
    order_flags = '0;
    if (s1_a_nan || s1_b_nan) begin
      order_flags[FLAG_UN] = 1'b1;
    end else if (s1_a_zero && s1_b_zero) begin
      order_flags[FLAG_EQ] = 1'b1;
    end else if (s1_a_neg != s1_b_neg) begin
      order_flags[FLAG_LT] = s1_a_neg;
      order_flags[FLAG_GT] = s1_b_neg;
    end else if (mag_eq) begin
      order_flags[FLAG_EQ] = 1'b1;
    end else begin
      // negative operands flip the magnitude order.
      order_flags[FLAG_LT] = mag_lt ^ s1_a_neg;
      order_flags[FLAG_GT] = ~(mag_lt ^ s1_a_neg);
    end
  end

  always_comb begin
    sel_data = s2_a;
    if (s2_op == OP_CMP_LO || s2_op == OP_CMP_HI) begin
      sel_data = s2_flags[FLAG_LT] ? '1 : '0;
    end else if (s2_a_nan || s2_b_nan) begin
      if (s2_mode && !s2_a_nan) begin
        sel_data = s2_a;
      end else if (s2_mode && !s2_b_nan) begin
        sel_data = s2_b;
      end else begin
        sel_data = QNAN;
      end
    end else if (s2_op == OP_MIN) begin
      sel_data = s2_flags[FLAG_GT] ? s2_b : s2_a;
    end else begin
      sel_data = s2_flags[FLAG_LT] ? s2_b : s2_a;
    end
  end

  always_ff @(posedge clk) begin
    // stage 1, classify.
    s1_op     <= op;
    s1_a      <= a;
    s1_b      <= b;
    s1_mode   <= nan_mode;
    s1_a_nan  <= is_nan(a);
    s1_b_nan  <= is_nan(b);
    s1_a_neg  <= a[31];
    s1_b_neg  <= b[31];
    s1_a_zero <= (a[30:0] == 31'd0);
    s1_b_zero <= (b[30:0] == 31'd0);
    // stage 2, order.
    s2_op     <= s1_op;
    s2_a      <= s1_a;
    s2_b      <= s1_b;
    s2_mode   <= s1_mode;
    s2_a_nan  <= s1_a_nan;
    s2_b_nan  <= s1_b_nan;
    s2_flags  <= order_flags;
    // stage 3, select.
    s3_data   <= sel_data;
    s3_flags  <= s2_flags;
    // stage 4, output.
    out_data  <= s3_data;
    out_flags <= s3_flags;
  end

endmodule

// File: fpu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fpu compare unit shared types
// widths, op codes, flag bits, csr
// map and bus structs.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fpu_pkg;

  // number format.
  localparam int unsigned FP_W   = 32;
  localparam int unsigned VEC_W  = 2 * FP_W;
  localparam int unsigned OP_W   = 2;
  localparam int unsigned FLAG_W = 4;

  // apb bus widths.
  localparam int unsigned APB_AW = 8;
  localparam int unsigned APB_DW = 32;

  typedef logic [FP_W-1:0]   fp_word_t;
  typedef logic [VEC_W-1:0]  fp_vec_t;
  typedef logic [OP_W-1:0]   fpu_op_t;
  typedef logic [FLAG_W-1:0] fp_flags_t;
  typedef logic [APB_AW-1:0] apb_addr_t;

  // op codes.
  localparam fpu_op_t OP_CMP_LO = 2'd0;
  localparam fpu_op_t OP_CMP_HI = 2'd1;
  localparam fpu_op_t OP_MIN    = 2'd2;
  localparam fpu_op_t OP_MAX    = 2'd3;

  // flag bit positions.
  localparam int unsigned FLAG_LT = 0;
  localparam int unsigned FLAG_EQ = 1;
  localparam int unsigned FLAG_GT = 2;
  localparam int unsigned FLAG_UN = 3;

  // canonical quiet nan.
  localparam fp_word_t QNAN = 32'h7fc0_0000;

  localparam int unsigned FPU_LATENCY = 4;

  typedef struct packed {
    logic    valid;
    fpu_op_t op;
    fp_vec_t a;
    fp_vec_t b;
  } fpu_req_t;

  typedef struct packed {
    logic      valid;
    fp_vec_t   data;
    fp_flags_t flags;
  } fpu_rsp_t;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    apb_addr_t         paddr;
    logic [APB_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // register map.
  localparam apb_addr_t CSR_CTRL   = 8'h00;
  localparam apb_addr_t CSR_STATUS = 8'h04;

endpackage
